// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, and check sim.log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --assert -j 0 -f all.f --top-module tb_wtmiss -o sim_tb
	./obj_dir/sim_tb > sim.log
	cat sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: all.f
wtmiss_pkg.sv
wtmiss_ram.sv
wtmiss_ctrl.sv
wtmiss_tlb_req.sv
wtmiss_inval.sv
wtmiss_out_mux.sv
wtmiss.sv
tb_wtmiss.sv
+incdir+.

// File: tb_wtmiss_model.svh
// reference model for the miss replay buffer, included inside the testbench module
// keeps captured entries and turns them into expected tlb requests and emits
`ifndef TB_WTMISS_MODEL_SVH
`define TB_WTMISS_MODEL_SVH

typedef struct {
  logic [lane_count-1:0]                   miss;
  logic [lane_count-1:0]                   valid;
  logic [lane_count-1:0][thread_width-1:0] thread;
  logic [lane_count-1:0][vaddr_width-1:0]  addr;
  logic [lane_count-1:0][sz_width-1:0]     sz;
  logic [lane_count-1:0][attr_width-1:0]   attr;
  logic [lane_count-1:0][lsq_width-1:0]    lsq;
} entry_t;

entry_t                          stored_q[$];
logic [vpn_width+attr_width-1:0] req_q[$];
entry_t                          emit_q[$];
// requests that must be acked before each emit
int                              emit_reqs_q[$];

// capture window is the idle cycle plus the gather delay, bounded by depth
function automatic void capture_entry(input entry_t e, input int idx);
  if (idx <= gather_delay && stored_q.size() < depth) begin
    stored_q.push_back(e);
  end
endfunction

function automatic void apply_except(input logic [thread_width-1:0] thr);
  foreach (stored_q[i]) begin
    for (int l = 0; l < lane_count; l++) begin
      if (stored_q[i].thread[l] == thr) begin
        stored_q[i].valid[l] = 1'b0;
      end
    end
  end
endfunction

function automatic void build_expect();
  int total;
  total = 0;
  foreach (stored_q[i]) begin
    for (int l = 0; l < lane_count; l++) begin
      if (stored_q[i].miss[l] && stored_q[i].valid[l]) begin
        req_q.push_back({stored_q[i].addr[l][vaddr_width-1:page_shift], stored_q[i].attr[l]});
        total++;
      end
    end
    if (|(stored_q[i].miss & stored_q[i].valid)) begin
      emit_q.push_back(stored_q[i]);
      emit_reqs_q.push_back(total);
    end
  end
  stored_q.delete();
endfunction

`endif

// File: tb_wtmiss.sv
// testbench for the miss replay buffer with random bursts, exceptions and a tlb responder
// results are checked against the queue model and summarized at the end
`timescale 1ns/1ns

module tb_wtmiss
  import wtmiss_pkg::*;
;
  `include "tb_wtmiss_model.svh"

  logic clk = 1'b0;
  logic rst;
  logic [lane_count-1:0] miss_i, op_en_i, op_en_o;
  logic [lane_count-1:0][thread_width-1:0] op_thread_i, op_thread_o;
  vaddr_u [lane_count-1:0] op_addr_i, op_addr_o;
  logic [lane_count-1:0][sz_width-1:0] op_sz_i, op_sz_o;
  logic [lane_count-1:0][attr_width-1:0] op_attr_i, op_attr_o;
  logic [lane_count-1:0][lsq_width-1:0] op_lsq_i, op_lsq_o;
  logic skip_o, tlb_req_o, except_i;
  logic tlb_ack_i = 1'b0;
  logic [vpn_width-1:0] tlb_vpn_o;
  logic [attr_width-1:0] tlb_attr_o;
  logic [thread_width-1:0] except_thread_i;

  localparam int num_bursts = 24;
  localparam int wait_limit = 300;
  integer seed = 32'h36f1;
  int errors = 0;
  int acks_seen = 0;
  int delays[256];
  int delay_idx = 0;
  int ack_wait = 0;
  bit in_req = 1'b0;
  logic prev_skip = 1'b0;
  logic [lane_count-1:0] prev_miss = '1;
  entry_t prev_op;

  wtmiss wtmiss_i (.*);

  always #50 clk = ~clk;

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic entry_t current_op();
    entry_t e;
    e.miss = miss_i;
    e.valid = op_en_i;
    e.thread = op_thread_i;
    e.sz = op_sz_i;
    e.attr = op_attr_i;
    e.lsq = op_lsq_i;
    for (int l = 0; l < lane_count; l++) e.addr[l] = op_addr_i[l].flat;
    return e;
  endfunction

  function automatic entry_t output_op();
    entry_t e;
    e.miss = '0;
    e.valid = op_en_o;
    e.thread = op_thread_o;
    e.sz = op_sz_o;
    e.attr = op_attr_o;
    e.lsq = op_lsq_o;
    for (int l = 0; l < lane_count; l++) e.addr[l] = op_addr_o[l].flat;
    return e;
  endfunction

  task automatic compare_lane(input entry_t got, input entry_t exp, input int l);
    check_val($sformatf("op_thread_o[%0d]", l), 64'(got.thread[l]), 64'(exp.thread[l]));
    check_val($sformatf("op_addr_o[%0d]", l), 64'(got.addr[l]), 64'(exp.addr[l]));
    check_val($sformatf("op_sz_o[%0d]", l), 64'(got.sz[l]), 64'(exp.sz[l]));
    check_val($sformatf("op_attr_o[%0d]", l), 64'(got.attr[l]), 64'(exp.attr[l]));
    check_val($sformatf("op_lsq_o[%0d]", l), 64'(got.lsq[l]), 64'(exp.lsq[l]));
  endtask

  task automatic drive_op(input logic [lane_count-1:0] miss);
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    miss_i = miss;
    // a lane can only miss when it carries an op
    op_en_i = r[lane_count-1:0] | miss;
    for (int l = 0; l < lane_count; l++) begin
      r = {$random(seed), $random(seed)};
      op_addr_i[l].flat = r[vaddr_width-1:0];
      r = {$random(seed), $random(seed)};
      op_thread_i[l] = r[thread_width-1:0];
      op_sz_i[l] = r[8 +: sz_width];
      op_attr_i[l] = r[16 +: attr_width];
      op_lsq_i[l] = r[24 +: lsq_width];
    end
  endtask

  // outputs are read mid cycle, against inputs driven in the cycle before
  always @(negedge clk) begin
    entry_t got;
    entry_t exp;
    int n;
    got = output_op();
    if (rst) begin
      prev_miss = '1;
    end else if (prev_skip) begin
      if (op_en_o != '0) begin
        assert (emit_q.size() > 0) else begin
          $display("op_en_o high while stalled with no replay due at t=%0t", $time);
          errors++;
        end
        if (emit_q.size() > 0) begin
          exp = emit_q.pop_front();
          n = emit_reqs_q.pop_front();
          check_val("op_en_o", 64'(op_en_o), 64'(exp.miss & exp.valid));
          assert (acks_seen >= n) else begin
            $display("replay emitted before its tlb acknowledge at t=%0t", $time);
            errors++;
          end
          for (int l = 0; l < lane_count; l++) begin
            if (exp.miss[l] && exp.valid[l]) compare_lane(got, exp, l);
          end
        end
      end
      if (!skip_o) begin
        assert (emit_q.size() == 0) else begin
          $display("skip_o fell with replays still pending at t=%0t", $time);
          errors++;
        end
      end
    end else if (prev_miss == '0) begin
      check_val("op_en_o", 64'(op_en_o), 64'(prev_op.valid));
      for (int l = 0; l < lane_count; l++) compare_lane(got, prev_op, l);
    end else begin
      // the captured cycle is held back from the pipeline
      check_val("op_en_o", 64'(op_en_o), 64'(0));
    end
    if (!rst) prev_miss = miss_i;
    prev_skip = skip_o;
    prev_op = current_op();
  end

  // second level tlb that acks each request after 0 to 3 cycles
  always @(posedge clk) begin
    #10;
    if (rst) begin
      tlb_ack_i = 1'b0;
      in_req = 1'b0;
    end else if (tlb_ack_i) begin
      tlb_ack_i = 1'b0;
      in_req = 1'b0;
      acks_seen++;
    end else if (tlb_req_o) begin
      if (!in_req) begin
        in_req = 1'b1;
        ack_wait = delays[delay_idx % 256];
        delay_idx++;
        assert (req_q.size() > 0) else begin
          $display("tlb request with no missing lane left to translate at t=%0t", $time);
          errors++;
        end
        if (req_q.size() > 0) begin
          check_val("tlb_vpn_o", 64'(tlb_vpn_o), 64'(req_q[0][attr_width +: vpn_width]));
          check_val("tlb_attr_o", 64'(tlb_attr_o), 64'(req_q[0][attr_width-1:0]));
          void'(req_q.pop_front());
        end
      end
      if (ack_wait == 0) tlb_ack_i = 1'b1;
      else ack_wait--;
    end
  end

  initial begin
    int k;
    int exc_idx;
    int last;
    int errs_before;
    int tests_run;
    bit done;
    logic [31:0] r;
    drive_op('0);
    op_en_i = '0;
    except_i = 1'b0;
    except_thread_i = '0;
    rst = 1'b1;
    for (int i = 0; i < 256; i++) delays[i] = $unsigned($random(seed)) % 4;
    repeat (2) @(posedge clk);
    #10;
    rst = 1'b0;
    @(negedge clk);
    check_val("skip_o", 64'(skip_o), 64'(0));
    check_val("tlb_req_o", 64'(tlb_req_o), 64'(0));
    check_val("op_en_o", 64'(op_en_o), 64'(0));
    // pass-through with no misses
    for (int c = 0; c < 20; c++) begin
      @(posedge clk);
      #10;
      check_val("skip_o", 64'(skip_o), 64'(0));
      drive_op('0);
    end
    $display("test 0 pass-through, errors %0d", errors);
    tests_run = 1;
    for (int t = 1; t <= num_bursts; t++) begin
      errs_before = errors;
      acks_seen = 0;
      r = $random(seed);
      k = 1 + int'(r[2:0]) % 5;
      // exception slot covers the capture, the gather and the first translate cycle
      exc_idx = r[8] ? int'(r[6:4]) % (gather_delay + 2) : -1;
      last = (k > gather_delay + 2) ? k : gather_delay + 2;
      for (int idx = 0; idx < last; idx++) begin
        @(posedge clk);
        #10;
        r = $random(seed);
        if (idx < k) drive_op(r[1:0] == 2'b00 ? 2'b01 : r[1:0]);
        else drive_op('0);
        except_i = (idx == exc_idx);
        except_thread_i = r[4 +: thread_width];
        if (idx < k) capture_entry(current_op(), idx);
        if (except_i) apply_except(except_thread_i);
      end
      build_expect();
      @(posedge clk);
      #10;
      drive_op('0);
      op_en_i = '0;
      except_i = 1'b0;
      done = 1'b0;
      for (int n = 0; n < wait_limit && !done; n++) begin
        @(posedge clk);
        #10;
        done = !skip_o && emit_q.size() == 0;
      end
      assert (done && req_q.size() == 0) else begin
        $display("replay of burst %0d did not finish in time, controller in %s", t,
                 wtmiss_i.ctrl_i.state_r.name());
        errors++;
      end
      $display("test %0d burst of %0d, exception %0d, errors %0d", t, k, exc_idx,
               errors - errs_before);
      tests_run++;
      if (!done) break;
    end
    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: wtmiss.sv
// dtlb miss replay buffer for the two lane load/store pipeline
// stalls issue with skip_o, fetches missing pages, then replays stored ops in order
`timescale 1ns/1ns

module wtmiss
  import wtmiss_pkg::*;
(
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [lane_count-1:0]                   miss_i,
  input  logic [lane_count-1:0]                   op_en_i,
  input  logic [lane_count-1:0][thread_width-1:0] op_thread_i,
  input  vaddr_u [lane_count-1:0]                 op_addr_i,
  input  logic [lane_count-1:0][sz_width-1:0]     op_sz_i,
  input  logic [lane_count-1:0][attr_width-1:0]   op_attr_i,
  input  logic [lane_count-1:0][lsq_width-1:0]    op_lsq_i,
  output logic [lane_count-1:0]                   op_en_o,
  output logic [lane_count-1:0][thread_width-1:0] op_thread_o,
  output vaddr_u [lane_count-1:0]                 op_addr_o,
  output logic [lane_count-1:0][sz_width-1:0]     op_sz_o,
  output logic [lane_count-1:0][attr_width-1:0]   op_attr_o,
  output logic [lane_count-1:0][lsq_width-1:0]    op_lsq_o,
  output logic                                    skip_o,
  output logic                                    tlb_req_o,
  output logic [vpn_width-1:0]                    tlb_vpn_o,
  output logic [attr_width-1:0]                   tlb_attr_o,
  input  logic                                    tlb_ack_i,
  input  logic                                    except_i,
  input  logic [thread_width-1:0]                 except_thread_i
);

  logic                                wr_en;
  logic [ptr_width-1:0]                wr_ptr;
  logic                                rd_en;
  logic [ptr_width-1:0]                rd_ptr;
  logic                                translate;
  logic                                emit;
  logic                                lanes_done;
  logic [lane_count-1:0]               head_miss;
  logic [lane_count-1:0]               head_invalid;
  logic [lane_count-1:0][op_width-1:0] head_word;

  wtmiss_ctrl ctrl_i (
    .clk          (clk),
    .rst          (rst),
    .miss_i       (miss_i),
    .lanes_done_i (lanes_done),
    .wr_en_o      (wr_en),
    .wr_ptr_o     (wr_ptr),
    .rd_en_o      (rd_en),
    .rd_ptr_o     (rd_ptr),
    .translate_o  (translate),
    .emit_o       (emit),
    .skip_o       (skip_o)
  );

  // one store per lane, miss flag on top of the op word
  for (genvar l = 0; l < lane_count; l++) begin : g_lane
    wtmiss_ram ram_i (
      .clk       (clk),
      .rst       (rst),
      .wr_en_i   (wr_en),
      .wr_ptr_i  (wr_ptr),
      .wr_data_i ({miss_i[l], op_thread_i[l], op_addr_i[l].flat, op_sz_i[l],
                   op_attr_i[l], op_lsq_i[l]}),
      .rd_en_i   (rd_en),
      .rd_ptr_i  (rd_ptr),
      .rd_data_o ({head_miss[l], head_word[l]})
    );
  end

  wtmiss_inval inval_i (
    .clk             (clk),
    .rst             (rst),
    .wr_en_i         (wr_en),
    .wr_ptr_i        (wr_ptr),
    .thread_i        (op_thread_i),
    .except_i        (except_i),
    .except_thread_i (except_thread_i),
    .rd_ptr_i        (rd_ptr),
    .head_invalid_o  (head_invalid)
  );

  wtmiss_tlb_req tlb_req_i (
    .clk            (clk),
    .rst            (rst),
    .translate_i    (translate),
    .head_miss_i    (head_miss),
    .head_invalid_i (head_invalid),
    .head_addr_i    ({head_word[1][off_addr +: vaddr_width],
                      head_word[0][off_addr +: vaddr_width]}),
    .head_attr_i    ({head_word[1][off_attr +: attr_width],
                      head_word[0][off_attr +: attr_width]}),
    .tlb_ack_i      (tlb_ack_i),
    .tlb_req_o      (tlb_req_o),
    .tlb_vpn_o      (tlb_vpn_o),
    .tlb_attr_o     (tlb_attr_o),
    .lanes_done_o   (lanes_done)
  );

  wtmiss_out_mux out_mux_i (
    .clk            (clk),
    .rst            (rst),
    .skip_i         (skip_o),
    .emit_i         (emit),
    .head_miss_i    (head_miss),
    .head_invalid_i (head_invalid),
    .head_word_i    (head_word),
    .miss_i         (miss_i),
    .op_en_i        (op_en_i),
    .op_thread_i    (op_thread_i),
    .op_addr_i      (op_addr_i),
    .op_sz_i        (op_sz_i),
    .op_attr_i      (op_attr_i),
    .op_lsq_i       (op_lsq_i),
    .op_en_o        (op_en_o),
    .op_thread_o    (op_thread_o),
    .op_addr_o      (op_addr_o),
    .op_sz_o        (op_sz_o),
    .op_attr_o      (op_attr_o),
    .op_lsq_o       (op_lsq_o)
  );

endmodule

// File: wtmiss_ctrl.sv
// sequencing for the miss replay buffer: capture, gather delay, per entry
// translate and emit, and the skip signal that stalls the pipeline
`timescale 1ns/1ns

module wtmiss_ctrl
  import wtmiss_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [lane_count-1:0] miss_i,
  input  logic                  lanes_done_i,
  output logic                  wr_en_o,
  output logic [ptr_width-1:0]  wr_ptr_o,
  output logic                  rd_en_o,
  output logic [ptr_width-1:0]  rd_ptr_o,
  output logic                  translate_o,
  output logic                  emit_o,
  output logic                  skip_o
);

  ctrl_state_e          state_r;
  logic [gdly_width-1:0] gcnt_r;
  logic [ptr_width-1:0] wr_ptr_r;
  logic [ptr_width-1:0] rd_ptr_r;
  logic [cnt_width-1:0] cnt_r;
  logic                 rd_pend_r;
  logic                 translate_r;
  logic                 accept;
  logic                 last_gather;

  // misses only land while idle or gathering, and only if there is room
  assign accept = (|miss_i) && (state_r == st_idle || state_r == st_gather) &&
                  (cnt_r < cnt_width'(depth));
  assign last_gather = (state_r == st_gather) &&
                       (gcnt_r == gdly_width'(gather_delay - 1));

  assign wr_en_o     = accept;
  assign wr_ptr_o    = wr_ptr_r;
  assign rd_en_o     = rd_pend_r;
  assign rd_ptr_o    = rd_ptr_r;
  assign translate_o = translate_r;
  assign emit_o      = (state_r == st_emit);
  assign skip_o      = (state_r != st_idle);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_r     <= st_idle;
      gcnt_r      <= '0;
      wr_ptr_r    <= '0;
      rd_ptr_r    <= '0;
      cnt_r       <= '0;
      rd_pend_r   <= 1'b0;
      translate_r <= 1'b0;
    end else begin
      // head word is on the ram output the cycle after the read
      translate_r <= rd_pend_r;
      rd_pend_r   <= 1'b0;

      if (accept) begin
        wr_ptr_r <= wr_ptr_r + ptr_width'(1);
        cnt_r    <= cnt_r + cnt_width'(1);
      end else if (emit_o) begin
        cnt_r <= cnt_r - cnt_width'(1);
      end

      case (state_r)
        st_idle: begin
          if (accept) begin
            state_r <= st_gather;
            gcnt_r  <= '0;
          end
        end
        st_gather: begin
          gcnt_r <= gcnt_r + gdly_width'(1);
          if (last_gather) begin
            state_r   <= st_translate;
            rd_pend_r <= 1'b1;
          end
        end
        st_translate: begin
          if (lanes_done_i) begin
            state_r <= st_emit;
          end
        end
        st_emit: begin
          rd_ptr_r <= rd_ptr_r + ptr_width'(1);
          if (cnt_r == cnt_width'(1)) begin
            state_r <= st_idle;
          end else begin
            state_r   <= st_translate;
            rd_pend_r <= 1'b1;
          end
        end
        default: state_r <= st_idle;
      endcase
    end
  end

endmodule

// File: wtmiss_inval.sv
// per entry and lane thread tags with invalid bits
// an exception kills every buffered lane of its thread
`timescale 1ns/1ns

module wtmiss_inval
  import wtmiss_pkg::*;
(
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    wr_en_i,
  input  logic [ptr_width-1:0]                    wr_ptr_i,
  input  logic [lane_count-1:0][thread_width-1:0] thread_i,
  input  logic                                    except_i,
  input  logic [thread_width-1:0]                 except_thread_i,
  input  logic [ptr_width-1:0]                    rd_ptr_i,
  output logic [lane_count-1:0]                   head_invalid_o
);

  logic [lane_count-1:0][thread_width-1:0] thr_r [depth];
  logic [lane_count-1:0]                   inv_r [depth];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      thr_r[wr_ptr_i] <= thread_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int e = 0; e < depth; e++) begin
        inv_r[e] <= '0;
      end
    end else begin
      if (except_i) begin
        for (int e = 0; e < depth; e++) begin
          for (int l = 0; l < lane_count; l++) begin
            if (thr_r[e][l] == except_thread_i) begin
              inv_r[e][l] <= 1'b1;
            end
          end
        end
      end
      // new entry overrides stale bits, same cycle exception still applies
      if (wr_en_i) begin
        for (int l = 0; l < lane_count; l++) begin
          inv_r[wr_ptr_i][l] <= except_i && (thread_i[l] == except_thread_i);
        end
      end
    end
  end

  assign head_invalid_o = inv_r[rd_ptr_i];

endmodule

// File: wtmiss_out_mux.sv
// registered op outputs: pipeline pass-through, replayed head entry, or blank
`timescale 1ns/1ns

module wtmiss_out_mux
  import wtmiss_pkg::*;
(
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    skip_i,
  input  logic                                    emit_i,
  input  logic [lane_count-1:0]                   head_miss_i,
  input  logic [lane_count-1:0]                   head_invalid_i,
  input  logic [lane_count-1:0][op_width-1:0]     head_word_i,
  input  logic [lane_count-1:0]                   miss_i,
  input  logic [lane_count-1:0]                   op_en_i,
  input  logic [lane_count-1:0][thread_width-1:0] op_thread_i,
  input  vaddr_u [lane_count-1:0]                 op_addr_i,
  input  logic [lane_count-1:0][sz_width-1:0]     op_sz_i,
  input  logic [lane_count-1:0][attr_width-1:0]   op_attr_i,
  input  logic [lane_count-1:0][lsq_width-1:0]    op_lsq_i,
  output logic [lane_count-1:0]                   op_en_o,
  output logic [lane_count-1:0][thread_width-1:0] op_thread_o,
  output vaddr_u [lane_count-1:0]                 op_addr_o,
  output logic [lane_count-1:0][sz_width-1:0]     op_sz_o,
  output logic [lane_count-1:0][attr_width-1:0]   op_attr_o,
  output logic [lane_count-1:0][lsq_width-1:0]    op_lsq_o
);

  logic hold_back;

  // a missing cycle goes into the buffer, so it is blanked here too
  assign hold_back = skip_i | (|miss_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      op_en_o <= '0;
    end else if (emit_i) begin
      op_en_o <= head_miss_i & ~head_invalid_i;
    end else if (hold_back) begin
      op_en_o <= '0;
    end else begin
      op_en_o <= op_en_i;
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < lane_count; l++) begin
      if (skip_i) begin
        op_thread_o[l]    <= head_word_i[l][off_thread +: thread_width];
        op_addr_o[l].flat <= head_word_i[l][off_addr +: vaddr_width];
        op_sz_o[l]        <= head_word_i[l][off_sz +: sz_width];
        op_attr_o[l]      <= head_word_i[l][off_attr +: attr_width];
        op_lsq_o[l]       <= head_word_i[l][off_lsq +: lsq_width];
      end else begin
        op_thread_o[l] <= op_thread_i[l];
        op_addr_o[l]   <= op_addr_i[l];
        op_sz_o[l]     <= op_sz_i[l];
        op_attr_o[l]   <= op_attr_i[l];
        op_lsq_o[l]    <= op_lsq_i[l];
      end
    end
  end

endmodule

// File: wtmiss_pkg.sv
// shared widths, stored word layout and types for the dtlb miss replay buffer
// each rtl module pulls these in with a wildcard import in its header
package wtmiss_pkg;

  localparam int lane_count   = 2;
  localparam int depth        = 4;
  localparam int ptr_width    = 2;
  localparam int cnt_width    = 3;
  localparam int vaddr_width  = 44;
  localparam int page_shift   = 14;
  localparam int vpn_width    = vaddr_width - page_shift;
  localparam int thread_width = 1;
  localparam int sz_width     = 5;
  localparam int attr_width   = 4;
  localparam int lsq_width    = 9;

  // cycles spent collecting misses before the first replay
  localparam int gather_delay = 3;
  localparam int gdly_width   = $clog2(gather_delay + 1);

  // stored op word, lsq index in the low bits, thread on top
  localparam int off_lsq    = 0;
  localparam int off_attr   = off_lsq + lsq_width;
  localparam int off_sz     = off_attr + attr_width;
  localparam int off_addr   = off_sz + sz_width;
  localparam int off_thread = off_addr + vaddr_width;
  localparam int op_width   = off_thread + thread_width;

  typedef struct packed {
    logic [vpn_width-1:0]  vpn;
    logic [page_shift-1:0] offset;
  } vaddr_page_t;

  // same 44 bits, seen flat by the buffer or split by the tlb request
  typedef union packed {
    logic [vaddr_width-1:0] flat;
    vaddr_page_t            page;
  } vaddr_u;

  typedef enum logic [1:0] {
    st_idle,
    st_gather,
    st_translate,
    st_emit
  } ctrl_state_e;

endpackage

// File: wtmiss_ram.sv
// four entry store for one lane of captured ops
// read address is registered, a write to the entry being read shows the new word
`timescale 1ns/1ns

module wtmiss_ram
  import wtmiss_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wr_en_i,
  input  logic [ptr_width-1:0] wr_ptr_i,
  input  logic [op_width:0]    wr_data_i,
  input  logic                 rd_en_i,
  input  logic [ptr_width-1:0] rd_ptr_i,
  output logic [op_width:0]    rd_data_o
);

  logic [op_width:0]    mem_r [depth];
  logic [ptr_width-1:0] rd_addr_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr_r <= '0;
    end else if (rd_en_i) begin
      rd_addr_r <= rd_ptr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem_r[wr_ptr_i] <= wr_data_i;
    end
  end

  // async read of the latched address gives write-first
  assign rd_data_o = mem_r[rd_addr_r];

endmodule

// File: wtmiss_tlb_req.sv
// page requests to the second level tlb for the head entry, lane 0 first
// request and data hold until ack, then drop for a cycle
`timescale 1ns/1ns

module wtmiss_tlb_req
  import wtmiss_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  translate_i,
  input  logic [lane_count-1:0]                 head_miss_i,
  input  logic [lane_count-1:0]                 head_invalid_i,
  input  vaddr_u [lane_count-1:0]               head_addr_i,
  input  logic [lane_count-1:0][attr_width-1:0] head_attr_i,
  input  logic                                  tlb_ack_i,
  output logic                                  tlb_req_o,
  output logic [vpn_width-1:0]                  tlb_vpn_o,
  output logic [attr_width-1:0]                 tlb_attr_o,
  output logic                                  lanes_done_o
);

  logic [lane_count-1:0] done_r;
  logic                  active_r;
  logic                  sel_r;
  logic [lane_count-1:0] need;
  logic [lane_count-1:0] req_mask;
  logic [lane_count-1:0] done_cur;
  logic                  active;
  logic                  launch;
  logic                  pick;

  assign need     = head_miss_i & ~head_invalid_i;
  assign req_mask = {lane_count{tlb_req_o}} & (lane_count'(1) << sel_r);

  // a lane invalidated before its request goes out counts as done
  assign done_cur = translate_i ? ~need :
                    done_r | (~need & ~req_mask) | (req_mask & {lane_count{tlb_ack_i}});

  assign active       = translate_i | active_r;
  assign lanes_done_o = active & (&done_cur);
  assign launch       = active & ~tlb_req_o & ~(&done_cur);
  assign pick         = done_cur[0];

  always_ff @(posedge clk) begin
    if (rst) begin
      active_r  <= 1'b0;
      done_r    <= '1;
      tlb_req_o <= 1'b0;
      sel_r     <= 1'b0;
    end else begin
      active_r <= active & ~lanes_done_o;
      if (active) begin
        done_r <= done_cur;
      end
      if (tlb_req_o && tlb_ack_i) begin
        tlb_req_o <= 1'b0;
      end else if (launch) begin
        tlb_req_o <= 1'b1;
        sel_r     <= pick;
      end
    end
  end

  // request payload, loaded only when a request starts
  always_ff @(posedge clk) begin
    if (launch) begin
      tlb_vpn_o  <= head_addr_i[pick].page.vpn;
      tlb_attr_o <= head_attr_i[pick];
    end
  end

endmodule
